// File: Bender.yml
package:
  name: pipeCore

sources:
  - logic/corePkg.sv
  - logic/instrDecoder.sv
  - logic/regFile.sv
  - logic/idExReg.sv
  - logic/execUnit.sv
  - logic/hazardCtrl.sv
  - logic/pipeCore.sv
  - target: simulation
    files:
      - bench/pipeCoreTb.sv

// File: bench/pipeCoreTb.sv
`timescale 1ns/1ps

module pipeCoreTb;
    import corePkg::*;

    localparam int clkPeriod      = 4;
    localparam int resetCycles    = 10;
    localparam int idleCycles     = 6;
    localparam int drainCycles    = 6;
    localparam int numTests       = 6;
    localparam int totalWords     = 20 + 150 + 150 + 120 + 150 + 100;
    localparam int watchdogCycles = totalWords * 8 + resetCycles + idleCycles
                                  + numTests * drainCycles;

    // one instruction as the model expects it in E and W
    typedef struct packed {
        logic       wr;
        logic       ill;
        logic       taken;
        logic [4:0] addr;
        wordT       data;
        wordT       target;
    } recT;

    logic        clk = 1'b0;
    logic        arstN;
    wordT        instr;
    wordT        pc;
    logic        instrValid;
    logic        hold;
    logic        redirect;
    wordT        redirectPc;
    logic        wbEn;
    regAddrT     wbAddr;
    wordT        wbData;
    logic        illegal;

    wordT        mirror [32];
    recT         eRec;
    recT         wRec;
    logic        expRedirect;
    logic        tookWord;
    logic        steered;
    wordT        steerPc;
    logic [31:0] rngState = 32'd57901;
    string       testName = "reset";
    int          errCount = 0;

    pipeCore pipeCore_i (
        .clk(clk), .arstN(arstN), .instr(instr), .pc(pc), .instrValid(instrValid),
        .hold(hold), .redirect(redirect), .redirectPc(redirectPc), .wbEn(wbEn),
        .wbAddr(wbAddr), .wbData(wbData), .illegal(illegal)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic wordT pickInstr(regAddrT regMask, int branchPct, int badPct);
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        logic [15:0] imm;
        logic [15:0] offset;
        logic [31:0] r;
        int          roll;
        wordT        word;
        rs     = regAddrT'(nextRand()) & regMask;
        rt     = regAddrT'(nextRand()) & regMask;
        rd     = regAddrT'(nextRand()) & regMask;
        r      = nextRand();
        imm    = r[31:16];
        offset = {{12{r[5]}}, r[5:2]};
        roll   = int'(nextRand() % 100);
        if (roll < badPct) begin
            // opcodes from 0x20 up and function codes 0x10..0x1f lie outside the subset
            if (r[0]) begin
                word = {1'b1, r[5:1], rs, rt, imm};
            end else begin
                word = {opSpecial, rs, rt, rd, 5'd0, 2'b01, r[4:1]};
            end
        end else if (roll < badPct + branchPct) begin
            case (int'(r[1:0]) % 3)
                0:       word = {opBeq, rs, rt, offset};
                1:       word = {opBne, rs, rt, offset};
                default: word = {opJ, r[31:6]};
            endcase
        end else begin
            case (int'(nextRand() % 11))
                0:       word = {opSpecial, rs, rt, rd, 5'd0, fnAddu};
                1:       word = {opSpecial, rs, rt, rd, 5'd0, fnSubu};
                2:       word = {opSpecial, rs, rt, rd, 5'd0, fnAnd};
                3:       word = {opSpecial, rs, rt, rd, 5'd0, fnOr};
                4:       word = {opSpecial, rs, rt, rd, 5'd0, fnXor};
                5:       word = {opSpecial, rs, rt, rd, 5'd0, fnSlt};
                6:       word = {opSpecial, 5'd0, rt, rd, r[10:6], fnSll};
                7:       word = {opAddiu, rs, rt, imm};
                8:       word = {opAndi, rs, rt, imm};
                9:       word = {opOri, rs, rt, imm};
                default: word = {opLui, 5'd0, rt, imm};
            endcase
        end
        return word;
    endfunction

    // executes one accepted word against the mirror, in program order
    function automatic recT modelInstr(wordT word, wordT wordPc);
        recT  r;
        wordT a;
        wordT b;
        wordT sImm;
        wordT zImm;
        wordT next;
        logic hasResult;
        r         = '0;
        a         = mirror[word[25:21]];
        b         = mirror[word[20:16]];
        sImm      = {{16{word[15]}}, word[15:0]};
        zImm      = {16'b0, word[15:0]};
        next      = wordPc + 32'd4;
        hasResult = 1'b1;
        r.addr    = word[20:16];
        case (word[31:26])
            opSpecial: begin
                r.addr = word[15:11];
                case (word[5:0])
                    fnAddu:  r.data = a + b;
                    fnSubu:  r.data = a - b;
                    fnAnd:   r.data = a & b;
                    fnOr:    r.data = a | b;
                    fnXor:   r.data = a ^ b;
                    fnSlt:   r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnSll:   r.data = b << word[10:6];
                    default: begin
                        hasResult = 1'b0;
                        r.ill     = 1'b1;
                    end
                endcase
            end
            opAddiu: r.data = a + sImm;
            opAndi:  r.data = a & zImm;
            opOri:   r.data = a | zImm;
            opLui:   r.data = {word[15:0], 16'b0};
            opBeq, opBne: begin
                hasResult = 1'b0;
                r.taken   = (word[31:26] == opBeq) ? (a == b) : (a != b);
                r.target  = next + (sImm << 2);
            end
            opJ: begin
                hasResult = 1'b0;
                r.taken   = 1'b1;
                r.target  = {next[31:28], word[25:0], 2'b00};
            end
            default: begin
                hasResult = 1'b0;
                r.ill     = 1'b1;
            end
        endcase
        // register 0 stays zero and never shows up in W
        r.wr = hasResult && (r.addr != 5'd0);
        if (r.wr) begin
            mirror[r.addr] = r.data;
        end
        return r;
    endfunction

    // reference pipeline advanced at each rising edge
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                mirror[i] = '0;
            end
            eRec     = '0;
            wRec     = '0;
            tookWord = 1'b0;
            steered  = 1'b0;
            steerPc  = '0;
        end else begin
            steered  = eRec.taken && !hold;
            steerPc  = eRec.target;
            tookWord = instrValid && !hold && !steered;
            wRec     = hold ? recT'('0) : eRec;
            if (!hold) begin
                eRec = tookWord ? modelInstr(instr, pc) : recT'('0);
            end
        end
    end

    assign expRedirect = eRec.taken && !hold;

    task automatic reportValue(string what, wordT expected, wordT actual);
        errCount++;
        $display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
    endtask

    task automatic reportFault(string msg);
        errCount++;
        $display("error in test %s: %s", testName, msg);
    endtask

    checkWbEn: assert property (@(posedge clk) disable iff (!arstN) wbEn == wRec.wr)
        else reportValue("wbEn", $sampled(wRec.wr), $sampled(wbEn));
    checkWbAddr: assert property (@(posedge clk) disable iff (!arstN)
        wbEn |-> (wbAddr == wRec.addr))
        else reportValue("wbAddr", $sampled(wRec.addr), $sampled(wbAddr));
    checkWbData: assert property (@(posedge clk) disable iff (!arstN)
        wbEn |-> (wbData == wRec.data))
        else reportValue("wbData", $sampled(wRec.data), $sampled(wbData));
    checkIllegal: assert property (@(posedge clk) disable iff (!arstN) illegal == wRec.ill)
        else reportValue("illegal", $sampled(wRec.ill), $sampled(illegal));
    checkRedirect: assert property (@(posedge clk) disable iff (!arstN)
        redirect == expRedirect)
        else reportValue("redirect", $sampled(expRedirect), $sampled(redirect));
    checkTarget: assert property (@(posedge clk) disable iff (!arstN)
        redirect |-> (redirectPc == eRec.target))
        else reportValue("redirectPc", $sampled(eRec.target), $sampled(redirectPc));
    holdStarvesW: assert property (@(posedge clk) disable iff (!arstN) hold |=> !wbEn)
        else reportFault("write-back enable high right after a hold cycle");
    holdBlocksRedirect: assert property (@(posedge clk) disable iff (!arstN)
        hold |-> !redirect)
        else reportFault("redirect high while hold is high");

    task automatic runTest(string name, int words, regAddrT regMask, int branchPct,
                           int badPct, int holdPct);
        int issued;
        int errBefore;
        issued    = 0;
        errBefore = errCount;
        testName  = name;
        while (issued < words) begin
            @(negedge clk);
            // a word leaves D when taken or squashed, a held word is shown again
            if (steered || tookWord || !instrValid) begin
                if (steered) begin
                    pc = steerPc;
                end else if (tookWord) begin
                    pc = pc + 32'd4;
                end
                instrValid = (nextRand() % 8) != 0;
                instr      = instrValid ? pickInstr(regMask, branchPct, badPct) : nextRand();
                if (instrValid) begin
                    issued++;
                end
            end
            hold = int'(nextRand() % 100) < holdPct;
        end
        while (instrValid) begin
            @(negedge clk);
            hold = 1'b0;
            if (steered || tookWord) begin
                pc         = steered ? steerPc : pc + 32'd4;
                instrValid = 1'b0;
            end
        end
        repeat (drainCycles) @(negedge clk);
        $display("test %s: %0d words, %0d errors", name, words, errCount - errBefore);
    endtask

    initial begin
        arstN      = 1'b0;
        instr      = '0;
        pc         = 32'h0000_1000;
        instrValid = 1'b0;
        hold       = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        // junk words with instrValid low must decode as bubbles
        repeat (idleCycles) begin
            @(negedge clk);
            instr = nextRand();
        end
        runTest("reset", 20, 5'd7, 10, 5, 10);
        runTest("alu", 150, 5'd31, 0, 0, 0);
        runTest("dependency", 150, 5'd3, 0, 0, 0);
        runTest("branch", 120, 5'd3, 35, 0, 10);
        runTest("hold", 150, 5'd7, 15, 5, 50);
        runTest("reserved", 100, 5'd3, 0, 25, 10);
        $display("%0d tests run, %0d errors", numTests, errCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("timeout: the run did not end within %0d cycles", watchdogCycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: logic/corePkg.sv
package corePkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [3:0]  aluCtrlT;
    typedef logic [1:0]  branchKindT;

    // alu operation select
    localparam aluCtrlT aluAdd = 4'd0;
    localparam aluCtrlT aluSub = 4'd1;
    localparam aluCtrlT aluAnd = 4'd2;
    localparam aluCtrlT aluOr  = 4'd3;
    localparam aluCtrlT aluXor = 4'd4;
    localparam aluCtrlT aluSlt = 4'd5;
    localparam aluCtrlT aluSll = 4'd6;
    localparam aluCtrlT aluLui = 4'd7;

    // branch kind resolved in execute
    localparam branchKindT brNone  = 2'd0;
    localparam branchKindT brEqual = 2'd1;
    localparam branchKindT brNotEq = 2'd2;
    localparam branchKindT brJump  = 2'd3;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;

    // function codes under opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

endpackage

// File: logic/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  logic                clk,
    input  logic                arstN,
    input  corePkg::wordT       rdA,
    input  corePkg::wordT       rdB,
    input  corePkg::wordT       imm,
    input  logic [4:0]          shamt,
    input  corePkg::wordT       pc,
    input  logic [25:0]         jumpIndex,
    input  corePkg::aluCtrlT    aluCtrl,
    input  logic                aluImmSel,
    input  corePkg::regAddrT    destReg,
    input  logic                regWriteEn,
    input  logic                reservedInstr,
    input  corePkg::branchKindT branchKind,
    input  logic                fwdA,
    input  logic                fwdB,
    input  logic                wbBubble,
    input  logic                redirectEn,
    output logic                branchTaken,
    output logic                redirect,
    output corePkg::wordT       redirectPc,
    output logic                wbEn,
    output corePkg::regAddrT    wbAddr,
    output corePkg::wordT       wbData,
    output logic                illegal
);
    import corePkg::*;

    wordT opA;
    wordT opB;
    wordT aluB;
    wordT result;
    wordT pcPlus4;
    wordT branchTarget;
    wordT jumpTarget;
    wordT heldA;
    wordT heldB;
    logic opsHeld;

    // a held instruction keeps the operands it resolved in its first hold cycle,
    // since the W producer it forwarded from retires during the hold
    assign opA  = opsHeld ? heldA : (fwdA ? wbData : rdA);
    assign opB  = opsHeld ? heldB : (fwdB ? wbData : rdB);
    assign aluB = aluImmSel ? imm : opB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opsHeld <= 1'b0;
        end else begin
            opsHeld <= wbBubble;
        end
    end

    always_ff @(posedge clk) begin
        if (wbBubble) begin
            heldA <= opA;
            heldB <= opB;
        end
    end

    always_comb begin
        case (aluCtrl)
            aluAdd:  result = opA + aluB;
            aluSub:  result = opA - aluB;
            aluAnd:  result = opA & aluB;
            aluOr:   result = opA | aluB;
            aluXor:  result = opA ^ aluB;
            aluSlt:  result = {31'b0, $signed(opA) < $signed(aluB)};
            aluSll:  result = aluB << shamt;
            aluLui:  result = {aluB[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    // no delay slot, targets are relative to pc + 4
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {imm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};

    always_comb begin
        case (branchKind)
            brEqual: branchTaken = (opA == opB);
            brNotEq: branchTaken = (opA != opB);
            brJump:  branchTaken = 1'b1;
            default: branchTaken = 1'b0;
        endcase
    end

    assign redirect   = redirectEn;
    assign redirectPc = (branchKind == brJump) ? jumpTarget : branchTarget;

    // write-back register, enables drop to a bubble under hold
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbEn    <= 1'b0;
            illegal <= 1'b0;
        end else if (wbBubble) begin
            wbEn    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            wbEn    <= regWriteEn;
            illegal <= reservedInstr;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= destReg;
        wbData <= result;
    end

    // decode drops register 0 writes before they reach W
    assert property (@(posedge clk) disable iff (!arstN) wbEn |-> (wbAddr != '0))
        else $error("execUnit: write-back targets register 0");

endmodule

// File: logic/hazardCtrl.sv
`timescale 1ns/1ps

module hazardCtrl (
    input  logic             hold,
    input  logic             branchTaken,
    input  logic             wbEn,
    input  corePkg::regAddrT rsE,
    input  corePkg::regAddrT rtE,
    input  corePkg::regAddrT wbAddr,
    output logic             stallE,
    output logic             flushE,
    output logic             wbBubble,
    output logic             redirectEn,
    output logic             fwdA,
    output logic             fwdB
);

    // hold freezes E and starves W
    assign stallE   = hold;
    assign wbBubble = hold;

    // a taken branch squashes the word presented in D and steers fetch
    assign flushE     = branchTaken && !hold;
    assign redirectEn = flushE;

    // forward from W when it writes a live register the E operand reads
    assign fwdA = wbEn && (wbAddr != '0) && (wbAddr == rsE);
    assign fwdB = wbEn && (wbAddr != '0) && (wbAddr == rtE);

endmodule

// File: logic/idExReg.sv
`timescale 1ns/1ps

module idExReg (
    input  logic                clk,
    input  logic                arstN,
    input  logic                stallE,
    input  logic                flushE,
    input  corePkg::regAddrT    rsD,
    input  corePkg::regAddrT    rtD,
    input  corePkg::regAddrT    destRegD,
    input  corePkg::wordT       rdAD,
    input  corePkg::wordT       rdBD,
    input  corePkg::wordT       immD,
    input  logic [4:0]          shamtD,
    input  corePkg::wordT       pcD,
    input  logic [25:0]         jumpIndexD,
    input  corePkg::aluCtrlT    aluCtrlD,
    input  logic                aluImmSelD,
    input  logic                regWriteEnD,
    input  logic                reservedInstrD,
    input  corePkg::branchKindT branchKindD,
    output corePkg::regAddrT    rsE,
    output corePkg::regAddrT    rtE,
    output corePkg::regAddrT    destRegE,
    output corePkg::wordT       rdAE,
    output corePkg::wordT       rdBE,
    output corePkg::wordT       immE,
    output logic [4:0]          shamtE,
    output corePkg::wordT       pcE,
    output logic [25:0]         jumpIndexE,
    output corePkg::aluCtrlT    aluCtrlE,
    output logic                aluImmSelE,
    output logic                regWriteEnE,
    output logic                reservedInstrE,
    output corePkg::branchKindT branchKindE
);

    // all-zero contents are a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rsE            <= '0;
            rtE            <= '0;
            destRegE       <= '0;
            rdAE           <= '0;
            rdBE           <= '0;
            immE           <= '0;
            shamtE         <= '0;
            pcE            <= '0;
            jumpIndexE     <= '0;
            aluCtrlE       <= '0;
            aluImmSelE     <= 1'b0;
            regWriteEnE    <= 1'b0;
            reservedInstrE <= 1'b0;
            branchKindE    <= '0;
        end else if (flushE) begin
            rsE            <= '0;
            rtE            <= '0;
            destRegE       <= '0;
            rdAE           <= '0;
            rdBE           <= '0;
            immE           <= '0;
            shamtE         <= '0;
            pcE            <= '0;
            jumpIndexE     <= '0;
            aluCtrlE       <= '0;
            aluImmSelE     <= 1'b0;
            regWriteEnE    <= 1'b0;
            reservedInstrE <= 1'b0;
            branchKindE    <= '0;
        end else if (!stallE) begin
            rsE            <= rsD;
            rtE            <= rtD;
            destRegE       <= destRegD;
            rdAE           <= rdAD;
            rdBE           <= rdBD;
            immE           <= immD;
            shamtE         <= shamtD;
            pcE            <= pcD;
            jumpIndexE     <= jumpIndexD;
            aluCtrlE       <= aluCtrlD;
            aluImmSelE     <= aluImmSelD;
            regWriteEnE    <= regWriteEnD;
            reservedInstrE <= reservedInstrD;
            branchKindE    <= branchKindD;
        end
    end

    // a taken branch is never resolved under hold
    assert property (@(posedge clk) disable iff (!arstN) !(flushE && stallE))
        else $error("idExReg: flush and stall asserted together");

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  corePkg::wordT       instr,
    input  logic                instrValid,
    output corePkg::regAddrT    rs,
    output corePkg::regAddrT    rt,
    output corePkg::regAddrT    destReg,
    output corePkg::wordT       imm,
    output logic [4:0]          shamt,
    output corePkg::aluCtrlT    aluCtrl,
    output logic                aluImmSel,
    output logic                regWriteEn,
    output logic                reservedInstr,
    output corePkg::branchKindT branchKind,
    output logic [25:0]         jumpIndex
);
    import corePkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] immField;
    logic        useRd;
    logic        writes;
    logic        signExt;
    logic        known;
    logic        immSel;
    aluCtrlT     aluSel;
    branchKindT  brSel;
    regAddrT     dest;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign immField = instr[15:0];

    always_comb begin
        useRd   = 1'b0;
        writes  = 1'b0;
        signExt = 1'b0;
        known   = 1'b1;
        immSel  = 1'b0;
        aluSel  = aluAdd;
        brSel   = brNone;
        case (opcode)
            opSpecial: begin
                useRd  = 1'b1;
                writes = 1'b1;
                case (funct)
                    fnAddu:  aluSel = aluAdd;
                    fnSubu:  aluSel = aluSub;
                    fnAnd:   aluSel = aluAnd;
                    fnOr:    aluSel = aluOr;
                    fnXor:   aluSel = aluXor;
                    fnSlt:   aluSel = aluSlt;
                    fnSll:   aluSel = aluSll;
                    default: begin
                        writes = 1'b0;
                        known  = 1'b0;
                    end
                endcase
            end
            opAddiu: begin
                writes  = 1'b1;
                immSel  = 1'b1;
                signExt = 1'b1;
            end
            opAndi: begin
                writes = 1'b1;
                immSel = 1'b1;
                aluSel = aluAnd;
            end
            opOri: begin
                writes = 1'b1;
                immSel = 1'b1;
                aluSel = aluOr;
            end
            opLui: begin
                writes = 1'b1;
                immSel = 1'b1;
                aluSel = aluLui;
            end
            opBeq: begin
                signExt = 1'b1;
                brSel   = brEqual;
            end
            opBne: begin
                signExt = 1'b1;
                brSel   = brNotEq;
            end
            opJ:     brSel = brJump;
            default: known = 1'b0;
        endcase
    end

    // r-type writes rd, immediate forms write rt
    assign dest = useRd ? instr[15:11] : instr[20:16];

    // an invalid slot decodes as a bubble
    assign rs         = instrValid ? instr[25:21] : '0;
    assign rt         = instrValid ? instr[20:16] : '0;
    assign destReg    = instrValid ? dest : '0;
    assign shamt      = instrValid ? instr[10:6] : '0;
    assign jumpIndex  = instrValid ? instr[25:0] : '0;
    assign aluCtrl    = instrValid ? aluSel : aluAdd;
    assign aluImmSel  = instrValid && immSel;
    assign branchKind = instrValid ? brSel : brNone;
    assign imm        = !instrValid ? '0
                      : signExt ? {{16{immField[15]}}, immField}
                      : {16'b0, immField};

    // writes to register 0 are dropped here so W never carries them
    assign regWriteEn    = instrValid && writes && (dest != '0);
    assign reservedInstr = instrValid && !known;

endmodule

// File: logic/pipeCore.sv
`timescale 1ns/1ps

module pipeCore (
    input  logic             clk,
    input  logic             arstN,
    input  corePkg::wordT    instr,
    input  corePkg::wordT    pc,
    input  logic             instrValid,
    input  logic             hold,
    output logic             redirect,
    output corePkg::wordT    redirectPc,
    output logic             wbEn,
    output corePkg::regAddrT wbAddr,
    output corePkg::wordT    wbData,
    output logic             illegal
);
    import corePkg::*;

    // decode stage
    regAddrT    rsD;
    regAddrT    rtD;
    regAddrT    destRegD;
    wordT       rdAD;
    wordT       rdBD;
    wordT       immD;
    logic [4:0] shamtD;
    logic [25:0] jumpIndexD;
    aluCtrlT    aluCtrlD;
    logic       aluImmSelD;
    logic       regWriteEnD;
    logic       reservedInstrD;
    branchKindT branchKindD;

    // execute stage
    regAddrT    rsE;
    regAddrT    rtE;
    regAddrT    destRegE;
    wordT       rdAE;
    wordT       rdBE;
    wordT       immE;
    logic [4:0] shamtE;
    wordT       pcE;
    logic [25:0] jumpIndexE;
    aluCtrlT    aluCtrlE;
    logic       aluImmSelE;
    logic       regWriteEnE;
    logic       reservedInstrE;
    branchKindT branchKindE;

    // control
    logic stallE;
    logic flushE;
    logic wbBubble;
    logic redirectEn;
    logic fwdA;
    logic fwdB;
    logic branchTaken;

    instrDecoder instrDecoder_i (
        .instr(instr), .instrValid(instrValid),
        .rs(rsD), .rt(rtD), .destReg(destRegD), .imm(immD), .shamt(shamtD),
        .aluCtrl(aluCtrlD), .aluImmSel(aluImmSelD), .regWriteEn(regWriteEnD),
        .reservedInstr(reservedInstrD), .branchKind(branchKindD), .jumpIndex(jumpIndexD)
    );

    regFile regFile_i (
        .clk(clk), .arstN(arstN),
        .rdAddrA(rsD), .rdAddrB(rtD), .rdDataA(rdAD), .rdDataB(rdBD),
        .wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData)
    );

    idExReg idExReg_i (
        .clk(clk), .arstN(arstN), .stallE(stallE), .flushE(flushE),
        .rsD(rsD), .rtD(rtD), .destRegD(destRegD), .rdAD(rdAD), .rdBD(rdBD),
        .immD(immD), .shamtD(shamtD), .pcD(pc), .jumpIndexD(jumpIndexD),
        .aluCtrlD(aluCtrlD), .aluImmSelD(aluImmSelD), .regWriteEnD(regWriteEnD),
        .reservedInstrD(reservedInstrD), .branchKindD(branchKindD),
        .rsE(rsE), .rtE(rtE), .destRegE(destRegE), .rdAE(rdAE), .rdBE(rdBE),
        .immE(immE), .shamtE(shamtE), .pcE(pcE), .jumpIndexE(jumpIndexE),
        .aluCtrlE(aluCtrlE), .aluImmSelE(aluImmSelE), .regWriteEnE(regWriteEnE),
        .reservedInstrE(reservedInstrE), .branchKindE(branchKindE)
    );

    execUnit execUnit_i (
        .clk(clk), .arstN(arstN),
        .rdA(rdAE), .rdB(rdBE), .imm(immE), .shamt(shamtE), .pc(pcE),
        .jumpIndex(jumpIndexE), .aluCtrl(aluCtrlE), .aluImmSel(aluImmSelE),
        .destReg(destRegE), .regWriteEn(regWriteEnE), .reservedInstr(reservedInstrE),
        .branchKind(branchKindE), .fwdA(fwdA), .fwdB(fwdB), .wbBubble(wbBubble),
        .redirectEn(redirectEn), .branchTaken(branchTaken), .redirect(redirect),
        .redirectPc(redirectPc), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .illegal(illegal)
    );

    hazardCtrl hazardCtrl_i (
        .hold(hold), .branchTaken(branchTaken), .wbEn(wbEn),
        .rsE(rsE), .rtE(rtE), .wbAddr(wbAddr),
        .stallE(stallE), .flushE(flushE), .wbBubble(wbBubble),
        .redirectEn(redirectEn), .fwdA(fwdA), .fwdB(fwdB)
    );

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  corePkg::regAddrT rdAddrA,
    input  corePkg::regAddrT rdAddrB,
    output corePkg::wordT    rdDataA,
    output corePkg::wordT    rdDataB,
    input  logic             wrEn,
    input  corePkg::regAddrT wrAddr,
    input  corePkg::wordT    wrData
);
    import corePkg::*;

    wordT regs [32];
    logic wrLive;

    // register 0 is never stored and never bypassed
    assign wrLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through so a reader two slots behind the producer sees the new value
    assign rdDataA = (wrLive && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrLive && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

    assert property (@(posedge clk) disable iff (!arstN)
        (rdAddrA == '0) |-> (rdDataA == '0))
        else $error("regFile: port A returned nonzero for register 0");

    assert property (@(posedge clk) disable iff (!arstN)
        (rdAddrB == '0) |-> (rdDataB == '0))
        else $error("regFile: port B returned nonzero for register 0");

endmodule

// File: project.f
logic/corePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/idExReg.sv
logic/execUnit.sv
logic/hazardCtrl.sv
logic/pipeCore.sv
bench/pipeCoreTb.sv
